// File: logic/i3c_pkg.sv
////////////////////////////////////////
// I3C bus watcher shared definitions
// Event kinds, widths and event word layout
////////////////////////////////////////

`default_nettype none

package i3c_pkg;

  localparam int unsigned TS_W   = 16;           // Wrapping cycle stamp
  localparam int unsigned TIME_W = 20;           // Timing inputs in clock cycles
  localparam int unsigned KIND_W = 2;
  localparam int unsigned EVT_W  = TS_W + KIND_W;

  // Monitor only produces START, STOP and HDR_EXIT
  typedef enum logic [KIND_W-1:0] {
    EVT_START    = 2'd0,
    EVT_RSTART   = 2'd1,  // Assigned by the tracker when the bus is busy
    EVT_STOP     = 2'd2,
    EVT_HDR_EXIT = 2'd3
  } evt_kind_e;

  // Kind in the top bits, timestamp below
  function automatic logic [EVT_W-1:0] evt_pack(evt_kind_e kind, logic [TS_W-1:0] ts);
    return {kind, ts};
  endfunction

  function automatic evt_kind_e evt_kind_of(logic [EVT_W-1:0] word);
    return evt_kind_e'(word[EVT_W-1 -: KIND_W]);
  endfunction

  function automatic logic [TS_W-1:0] evt_ts_of(logic [EVT_W-1:0] word);
    return word[TS_W-1:0];
  endfunction

endpackage

`default_nettype wire

// File: logic/line_filter.sv
////////////////////////////////////////
// Bus line filter
// Synchronizes one line and reports when its
// level has held for a programmed time
////////////////////////////////////////

`default_nettype none

module line_filter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        line_i,       // Asynchronous pin
  input  logic [i3c_pkg::TIME_W-1:0]  high_delay_i,
  input  logic [i3c_pkg::TIME_W-1:0]  low_delay_i,
  output logic                        level_o,
  output logic                        stable_high_o,
  output logic                        stable_low_o
);

  logic [1:0]                   sync_q;
  logic [i3c_pkg::TIME_W-1:0]   run_cnt_q;
  logic                         level_change;

  // Idle bus is pulled high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], line_i};
    end
  end

  assign level_o      = sync_q[1];
  assign level_change = sync_q[0] != sync_q[1];  // level_o flips next cycle

  // Cycles spent at the current level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_cnt_q <= '1;  // Treated as long settled out of reset
    end else if (level_change) begin
      run_cnt_q <= '0;
    end else if (run_cnt_q != '1) begin
      run_cnt_q <= run_cnt_q + 1'b1;
    end
  end

  assign stable_high_o = level_o && (run_cnt_q >= high_delay_i);
  assign stable_low_o  = !level_o && (run_cnt_q >= low_delay_i);

  // A fresh level only counts as stable with a zero delay
  a_stable_restart: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    level_o != $past(level_o) |->
      (!stable_high_o || high_delay_i == '0) && (!stable_low_o || low_delay_i == '0)
  );

endmodule

`default_nettype wire

// File: logic/bus_monitor.sv
////////////////////////////////////////
// Bus condition monitor
// Detects START, STOP and HDR exit and pushes
// timestamped events toward the FIFO
////////////////////////////////////////

`default_nettype none

module bus_monitor (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        enable_i,
  input  logic                        scl_level_i,
  input  logic                        scl_stable_high_i,
  input  logic                        scl_stable_low_i,
  input  logic                        sda_level_i,
  input  logic                        sda_stable_high_i,
  input  logic [i3c_pkg::TIME_W-1:0]  t_hd_dat_i,
  input  logic                        hdr_mode_i,
  input  logic                        wr_ready_i,
  output logic                        wr_valid_o,
  output logic [i3c_pkg::EVT_W-1:0]   wr_data_o,
  output logic                        overflow_o
);

  logic                         scl_q;
  logic                         sda_q;
  logic                         scl_edge;
  logic                         sda_fall;
  logic                         sda_rise;

  logic                         start_trig;
  logic                         stop_trig;
  logic                         start_pend_q;
  logic                         stop_pend_q;
  logic                         start_conf;
  logic                         stop_conf;
  logic [i3c_pkg::TIME_W-1:0]   hold_cnt_q;

  logic                         hdr_trig;
  logic                         hdr_pend_q;
  logic [4:0]                   hdr_shift_q;
  logic                         hdr_exit;

  logic [i3c_pkg::TS_W-1:0]     ts_q;
  i3c_pkg::evt_kind_e           conf_kind;

  // Previous levels for edge finding
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q <= 1'b1;
      sda_q <= 1'b1;
    end else begin
      scl_q <= scl_level_i;
      sda_q <= sda_level_i;
    end
  end

  assign scl_edge = scl_q != scl_level_i;
  assign sda_fall = sda_q && !sda_level_i;
  assign sda_rise = !sda_q && sda_level_i;

  // SDA edge under a settled SCL high and away from SCL edges
  assign start_trig = enable_i && scl_stable_high_i && sda_fall && !scl_edge;
  assign stop_trig  = enable_i && scl_stable_high_i && sda_rise && !scl_edge;

  assign start_conf = enable_i && scl_level_i && start_pend_q && (hold_cnt_q >= t_hd_dat_i);
  assign stop_conf  = enable_i && scl_level_i && stop_pend_q && (hold_cnt_q >= t_hd_dat_i);

  // One hold counter serves both conditions
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= '0;
    end else if (start_trig || stop_trig) begin
      hold_cnt_q <= {{(i3c_pkg::TIME_W-1){1'b0}}, 1'b1};
    end else if ((start_pend_q || stop_pend_q) && hold_cnt_q != '1) begin
      hold_cnt_q <= hold_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pend_q <= 1'b0;
      stop_pend_q  <= 1'b0;
    end else begin
      if (start_trig) begin
        start_pend_q <= 1'b1;
      end else if (!enable_i || !scl_level_i || start_conf || stop_trig) begin
        start_pend_q <= 1'b0;  // SCL dropped before the hold time
      end
      if (stop_trig) begin
        stop_pend_q <= 1'b1;
      end else if (!enable_i || !scl_level_i || stop_conf || start_trig) begin
        stop_pend_q <= 1'b0;
      end
    end
  end

  // HDR exit pattern is SCL low, four SDA falls, then a STOP
  assign hdr_trig = hdr_mode_i && scl_stable_low_i && sda_stable_high_i;
  assign hdr_exit = hdr_pend_q && hdr_shift_q[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_pend_q <= 1'b0;
    end else if (hdr_trig) begin
      hdr_pend_q <= 1'b1;
    end else if (!enable_i || stop_conf) begin
      hdr_pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_shift_q <= 5'b10000;
    end else if (!enable_i || stop_conf) begin
      hdr_shift_q <= 5'b10000;
    end else if (hdr_pend_q && sda_fall) begin
      hdr_shift_q <= {1'b0, hdr_shift_q[4:1]};  // One step per SDA fall
    end
  end

  // Free-running stamp that wraps
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ts_q <= '0;
    end else begin
      ts_q <= ts_q + 1'b1;
    end
  end

  always_comb begin
    if (start_conf) begin
      conf_kind = i3c_pkg::EVT_START;
    end else if (hdr_exit) begin
      conf_kind = i3c_pkg::EVT_HDR_EXIT;
    end else begin
      conf_kind = i3c_pkg::EVT_STOP;
    end
  end

  // Push one cycle after confirmation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_valid_o <= 1'b0;
    end else begin
      wr_valid_o <= start_conf || stop_conf;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_conf || stop_conf) begin
      wr_data_o <= i3c_pkg::evt_pack(conf_kind, ts_q);
    end
  end

  // Lost events latch the flag until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      overflow_o <= 1'b0;
    end else if (wr_valid_o && !wr_ready_i) begin
      overflow_o <= 1'b1;
    end
  end

  a_no_start_with_stop: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(start_conf && stop_conf)
  );

endmodule

`default_nettype wire

// File: logic/event_fifo.sv
////////////////////////////////////////
// Event FIFO
// Circular buffer of event words with
// valid/ready on both sides
////////////////////////////////////////

`default_nettype none

module event_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wr_valid_i,
  input  logic [i3c_pkg::EVT_W-1:0]  wr_data_i,
  output logic                       wr_ready_o,
  output logic                       rd_valid_o,
  output logic [i3c_pkg::EVT_W-1:0]  rd_data_o,
  input  logic                       rd_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [i3c_pkg::EVT_W-1:0]  mem_q [DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [CNT_W-1:0]           count_q;
  logic                       push;
  logic                       pop;

  assign wr_ready_o = count_q != CNT_W'(DEPTH);
  assign rd_valid_o = count_q != '0;
  assign rd_data_o  = mem_q[rd_ptr_q];

  assign push = wr_valid_i && wr_ready_o;
  assign pop  = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_count_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(DEPTH)
  );

  // Head word must not move under a stalled reader
  a_rd_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o)
  );

endmodule

`default_nettype wire

// File: logic/bus_state_tracker.sv
////////////////////////////////////////
// Bus state tracker
// Tracks bus busy, marks repeated START and
// holds one event for the output port
////////////////////////////////////////

`default_nettype none

module bus_state_tracker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       rd_valid_i,
  input  logic [i3c_pkg::EVT_W-1:0]  rd_data_i,
  output logic                       rd_ready_o,
  output logic                       evt_valid_o,
  output i3c_pkg::evt_kind_e         evt_kind_o,
  output logic [i3c_pkg::TS_W-1:0]   evt_ts_o,
  input  logic                       evt_ready_i,
  output logic                       bus_busy_o
);

  logic                load;
  i3c_pkg::evt_kind_e  in_kind;

  assign in_kind    = i3c_pkg::evt_kind_of(rd_data_i);
  assign rd_ready_o = !evt_valid_o || evt_ready_i;  // Empty or draining now
  assign load       = rd_valid_i && rd_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_valid_o <= 1'b0;
    end else if (load) begin
      evt_valid_o <= 1'b1;
    end else if (evt_ready_i) begin
      evt_valid_o <= 1'b0;
    end
  end

  // Busy follows the output register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_busy_o <= 1'b0;
    end else if (load) begin
      case (in_kind)
        i3c_pkg::EVT_START:    bus_busy_o <= 1'b1;
        i3c_pkg::EVT_STOP:     bus_busy_o <= 1'b0;
        i3c_pkg::EVT_HDR_EXIT: bus_busy_o <= 1'b0;
        default:               bus_busy_o <= bus_busy_o;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      if (in_kind == i3c_pkg::EVT_START && bus_busy_o) begin
        evt_kind_o <= i3c_pkg::EVT_RSTART;  // START inside a transfer
      end else begin
        evt_kind_o <= in_kind;
      end
      evt_ts_o <= i3c_pkg::evt_ts_of(rd_data_i);
    end
  end

  // A stalled event keeps its valid and its contents
  a_out_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    evt_valid_o && !evt_ready_i |=>
      evt_valid_o && $stable(evt_kind_o) && $stable(evt_ts_o)
  );

endmodule

`default_nettype wire

// File: logic/i3c_bus_watch.sv
////////////////////////////////////////
// I3C receive bus watcher top level
// Filters SCL/SDA, detects bus conditions and
// queues them for a valid/ready consumer
////////////////////////////////////////

`default_nettype none

module i3c_bus_watch #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        enable_i,
  input  logic                        scl_i,
  input  logic                        sda_i,
  input  logic [i3c_pkg::TIME_W-1:0]  t_hd_dat_i,
  input  logic [i3c_pkg::TIME_W-1:0]  t_r_i,
  input  logic [i3c_pkg::TIME_W-1:0]  t_f_i,
  input  logic                        hdr_mode_i,
  output logic                        evt_valid_o,
  output i3c_pkg::evt_kind_e          evt_kind_o,
  output logic [i3c_pkg::TS_W-1:0]    evt_ts_o,
  input  logic                        evt_ready_i,
  output logic                        bus_busy_o,
  output logic                        overflow_o
);

  logic                       scl_level;
  logic                       scl_stable_high;
  logic                       scl_stable_low;
  logic                       sda_level;
  logic                       sda_stable_high;

  logic                       wr_valid;
  logic                       wr_ready;
  logic [i3c_pkg::EVT_W-1:0]  wr_data;
  logic                       rd_valid;
  logic                       rd_ready;
  logic [i3c_pkg::EVT_W-1:0]  rd_data;

  line_filter i_scl_filter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .line_i        (scl_i),
    .high_delay_i  (t_r_i),
    .low_delay_i   (t_f_i),
    .level_o       (scl_level),
    .stable_high_o (scl_stable_high),
    .stable_low_o  (scl_stable_low)
  );

  // SDA low stability is not used by the monitor
  line_filter i_sda_filter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .line_i        (sda_i),
    .high_delay_i  (t_r_i),
    .low_delay_i   (t_f_i),
    .level_o       (sda_level),
    .stable_high_o (sda_stable_high),
    .stable_low_o  ()
  );

  bus_monitor i_bus_monitor (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .enable_i          (enable_i),
    .scl_level_i       (scl_level),
    .scl_stable_high_i (scl_stable_high),
    .scl_stable_low_i  (scl_stable_low),
    .sda_level_i       (sda_level),
    .sda_stable_high_i (sda_stable_high),
    .t_hd_dat_i        (t_hd_dat_i),
    .hdr_mode_i        (hdr_mode_i),
    .wr_ready_i        (wr_ready),
    .wr_valid_o        (wr_valid),
    .wr_data_o         (wr_data),
    .overflow_o        (overflow_o)
  );

  event_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) i_event_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_valid_i (wr_valid),
    .wr_data_i  (wr_data),
    .wr_ready_o (wr_ready),
    .rd_valid_o (rd_valid),
    .rd_data_o  (rd_data),
    .rd_ready_i (rd_ready)
  );

  bus_state_tracker i_bus_state_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_valid_i  (rd_valid),
    .rd_data_i   (rd_data),
    .rd_ready_o  (rd_ready),
    .evt_valid_o (evt_valid_o),
    .evt_kind_o  (evt_kind_o),
    .evt_ts_o    (evt_ts_o),
    .evt_ready_i (evt_ready_i),
    .bus_busy_o  (bus_busy_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_bus_tasks.svh
////////////////////////////////////////
// Bus stimulus and check helpers
// SCL/SDA waveforms, LCG and compare functions
////////////////////////////////////////

`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// 32-bit LCG, upper bits returned
function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return (lcg_state >> 16) & 32'h7fff;
endfunction

// One clock; inputs change on the falling edge
task automatic step();
  @(negedge clk_i);
  if (ready_mode == READY_RAND) begin
    evt_ready_i = (lcg_next() % 4) != 0;  // Stall about one cycle in four
  end else begin
    evt_ready_i = (ready_mode == READY_HIGH);
  end
endtask

task automatic drive_lines(input logic scl, input logic sda, input int cycles);
  step();
  scl_i = scl;
  sda_i = sda;
  repeat (cycles - 1) step();
endtask

// Entered from idle or from SCL low, SDA low
task automatic send_start();
  drive_lines(1'b1, 1'b1, PHASE);
  drive_lines(1'b1, 1'b0, PHASE);
  drive_lines(1'b0, 1'b0, PHASE);
endtask

task automatic send_rstart();
  drive_lines(1'b0, 1'b1, PHASE);  // SDA released while SCL low
  drive_lines(1'b1, 1'b1, PHASE);
  drive_lines(1'b1, 1'b0, PHASE);
  drive_lines(1'b0, 1'b0, PHASE);
endtask

task automatic send_stop();
  drive_lines(1'b0, 1'b0, PHASE);
  drive_lines(1'b1, 1'b0, PHASE);
  drive_lines(1'b1, 1'b1, PHASE);
endtask

// SCL low with SDA high, then SDA falls, then a STOP
task automatic send_hdr_exit(input int falls);
  hdr_mode_i = 1'b1;
  drive_lines(1'b0, 1'b1, PHASE);
  for (int i = 0; i < falls; i++) begin
    if (i != 0) begin
      drive_lines(1'b0, 1'b1, PHASE);
    end
    drive_lines(1'b0, 1'b0, PHASE);
  end
  drive_lines(1'b1, 1'b0, PHASE);
  drive_lines(1'b1, 1'b1, PHASE);
  hdr_mode_i = 1'b0;
endtask

// One-cycle SDA dip right after SCL rises, before SCL counts as stable
task automatic send_short_pulse();
  drive_lines(1'b0, 1'b1, PHASE);
  drive_lines(1'b1, 1'b1, 1);
  drive_lines(1'b1, 1'b0, 1);
  drive_lines(1'b1, 1'b1, PHASE);
endtask

task automatic send_both_edges();
  drive_lines(1'b0, 1'b0, PHASE);
  drive_lines(1'b1, 1'b1, PHASE);
endtask

task automatic play_conditions();
  foreach (cond_q[i]) begin
    case (cond_q[i])
      i3c_pkg::EVT_START: send_start();
      i3c_pkg::EVT_STOP:  send_stop();
      default:            send_hdr_exit(4);
    endcase
  end
endtask

function automatic bit check_kind(i3c_pkg::evt_kind_e got, i3c_pkg::evt_kind_e exp);
  if (got != exp) begin
    $display("error @ %0t: event kind %s, expected %s", $time, got.name(), exp.name());
    return 1'b0;
  end
  return 1'b1;
endfunction

function automatic bit check_busy(logic got, logic exp);
  if (got !== exp) begin
    $display("error @ %0t: bus_busy_o is %b, expected %b", $time, got, exp);
    return 1'b0;
  end
  return 1'b1;
endfunction

function automatic bit check_ts_increasing(logic [i3c_pkg::TS_W-1:0] prev,
                                           logic [i3c_pkg::TS_W-1:0] cur);
  if (cur <= prev) begin
    $display("error @ %0t: timestamp %0d not after %0d", $time, cur, prev);
    return 1'b0;
  end
  return 1'b1;
endfunction

function automatic bit check_overflow(logic got, logic exp);
  if (got !== exp) begin
    $display("error @ %0t: overflow_o is %b, expected %b", $time, got, exp);
    return 1'b0;
  end
  return 1'b1;
endfunction

`endif

// File: sim/tb_i3c_bus_watch.sv
////////////////////////////////////////
// Testbench for the I3C bus watcher
// Drives SCL/SDA sequences and checks the event stream
////////////////////////////////////////

`default_nettype none

module tb_i3c_bus_watch;

  localparam int          PHASE         = 20;  // Cycles per bus phase
  localparam int          CLK_PERIOD    = 8;
  localparam int          SETTLE_CYCLES = 2 * PHASE;
  localparam int unsigned LCG_SEED      = 57583;
  localparam int          READY_LOW     = 0;
  localparam int          READY_HIGH    = 1;
  localparam int          READY_RAND    = 2;
  // Bus phases of tests 1 to 6, plus reset and drain per test
  localparam int          TEST_PHASES   = 6 + 10 + 10 + 24 + 24 + 400 + 6 * 3;
  localparam int          WATCHDOG_TIME = 2 * TEST_PHASES * PHASE * CLK_PERIOD;

  typedef i3c_pkg::evt_kind_e kind_q_t [$];

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        enable_i;
  logic                        scl_i;
  logic                        sda_i;
  logic [i3c_pkg::TIME_W-1:0]  t_hd_dat_i;
  logic [i3c_pkg::TIME_W-1:0]  t_r_i;
  logic [i3c_pkg::TIME_W-1:0]  t_f_i;
  logic                        hdr_mode_i;
  logic                        evt_valid_o;
  i3c_pkg::evt_kind_e          evt_kind_o;
  logic [i3c_pkg::TS_W-1:0]    evt_ts_o;
  logic                        evt_ready_i;
  logic                        bus_busy_o;
  logic                        overflow_o;

  int unsigned                 lcg_state;
  int                          ready_mode;
  kind_q_t                     cond_q;      // Bus conditions sent in a test
  kind_q_t                     exp_q;       // Expected output kinds
  int                          got_cnt;
  int                          cmp_errors;
  int                          seq_errors;
  int                          err_base;
  int                          n_tests;
  int                          n_failed;
  logic [i3c_pkg::TS_W-1:0]    prev_ts;
  bit                          have_prev_ts;

  `include "tb_bus_tasks.svh"

  i3c_bus_watch #(
    .FIFO_DEPTH (4)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .enable_i    (enable_i),
    .scl_i       (scl_i),
    .sda_i       (sda_i),
    .t_hd_dat_i  (t_hd_dat_i),
    .t_r_i       (t_r_i),
    .t_f_i       (t_f_i),
    .hdr_mode_i  (hdr_mode_i),
    .evt_valid_o (evt_valid_o),
    .evt_kind_o  (evt_kind_o),
    .evt_ts_o    (evt_ts_o),
    .evt_ready_i (evt_ready_i),
    .bus_busy_o  (bus_busy_o),
    .overflow_o  (overflow_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // START opens a transfer, STOP and HDR exit close it
  function automatic kind_q_t ref_classify(kind_q_t conds);
    kind_q_t outs;
    logic    busy;
    busy = 1'b0;
    foreach (conds[i]) begin
      if (conds[i] == i3c_pkg::EVT_START) begin
        outs.push_back(busy ? i3c_pkg::EVT_RSTART : i3c_pkg::EVT_START);
        busy = 1'b1;
      end else begin
        outs.push_back(conds[i]);
        busy = 1'b0;
      end
    end
    return outs;
  endfunction

  function automatic logic busy_after(i3c_pkg::evt_kind_e kind);
    return kind == i3c_pkg::EVT_START || kind == i3c_pkg::EVT_RSTART;
  endfunction

  // Checks every accepted output event against the expected list
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      got_cnt      = 0;
      have_prev_ts = 1'b0;
    end else if (evt_valid_o && evt_ready_i) begin
      if (got_cnt >= exp_q.size()) begin
        $display("unexpected %s event at time %0t", evt_kind_o.name(), $time);
        cmp_errors++;
      end else begin
        if (!check_kind(evt_kind_o, exp_q[got_cnt])) cmp_errors++;
        if (!check_busy(bus_busy_o, busy_after(exp_q[got_cnt]))) cmp_errors++;
      end
      if (have_prev_ts && !check_ts_increasing(prev_ts, evt_ts_o)) cmp_errors++;
      prev_ts      = evt_ts_o;
      have_prev_ts = 1'b1;
      got_cnt++;
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: tests did not finish within %0d time units", WATCHDOG_TIME);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic do_reset();
    step();
    rst_ni     = 1'b0;
    scl_i      = 1'b1;
    sda_i      = 1'b1;
    hdr_mode_i = 1'b0;
    enable_i   = 1'b1;
    repeat (2) step();
    rst_ni = 1'b1;
  endtask

  // A negative keep means all expected events
  task automatic start_test(input int keep);
    exp_q = ref_classify(cond_q);
    if (keep >= 0) begin
      while (exp_q.size() > keep) exp_q.pop_back();
    end
    err_base = cmp_errors + seq_errors;
    do_reset();
  endtask

  task automatic end_test(input string name, input logic exp_ovf);
    int   errs;
    logic exp_busy;
    ready_mode = READY_HIGH;
    while (got_cnt < exp_q.size()) step();
    repeat (SETTLE_CYCLES) step();
    exp_busy = (exp_q.size() > 0) ? busy_after(exp_q[$]) : 1'b0;
    if (!check_busy(bus_busy_o, exp_busy)) seq_errors++;
    if (!check_overflow(overflow_o, exp_ovf)) seq_errors++;
    n_tests++;
    errs = cmp_errors + seq_errors - err_base;
    if (errs != 0) n_failed++;
    $display("test %0d %s: %s, %0d events, %0d errors", n_tests, name,
             (errs == 0) ? "ok" : "failed", got_cnt, errs);
  endtask

  initial begin
    int unsigned pick;
    rst_ni      = 1'b0;
    enable_i    = 1'b1;
    scl_i       = 1'b1;
    sda_i       = 1'b1;
    t_hd_dat_i  = 20'd4;
    t_r_i       = 20'd3;
    t_f_i       = 20'd3;
    hdr_mode_i  = 1'b0;
    evt_ready_i = 1'b1;
    ready_mode  = READY_HIGH;
    lcg_state   = LCG_SEED;

    cond_q.delete();
    cond_q.push_back(i3c_pkg::EVT_START);
    cond_q.push_back(i3c_pkg::EVT_STOP);
    start_test(-1);
    play_conditions();
    end_test("start_stop", 1'b0);

    // Second START while busy comes out as RSTART
    cond_q.delete();
    cond_q.push_back(i3c_pkg::EVT_START);
    cond_q.push_back(i3c_pkg::EVT_START);
    cond_q.push_back(i3c_pkg::EVT_STOP);
    start_test(-1);
    send_start();
    send_rstart();
    send_stop();
    end_test("repeated_start", 1'b0);

    cond_q.delete();
    start_test(-1);
    send_short_pulse();
    // Zero rise time makes SCL stable at once, so only the edge rule blocks a STOP
    t_r_i = '0;
    send_both_edges();
    t_r_i = 20'd3;
    enable_i = 1'b0;
    send_start();
    send_stop();
    enable_i = 1'b1;
    end_test("glitch_and_disable", 1'b0);

    // Three falls is not an HDR exit, so the STOP stays a STOP
    cond_q.delete();
    cond_q.push_back(i3c_pkg::EVT_START);
    cond_q.push_back(i3c_pkg::EVT_HDR_EXIT);
    cond_q.push_back(i3c_pkg::EVT_START);
    cond_q.push_back(i3c_pkg::EVT_STOP);
    start_test(-1);
    send_start();
    send_hdr_exit(4);
    send_start();
    send_hdr_exit(3);
    end_test("hdr_exit", 1'b0);

    // FIFO of 4 plus the output register hold the first 5
    cond_q.delete();
    repeat (4) begin
      cond_q.push_back(i3c_pkg::EVT_START);
      cond_q.push_back(i3c_pkg::EVT_STOP);
    end
    ready_mode = READY_LOW;
    start_test(5);
    play_conditions();
    end_test("backpressure", 1'b1);

    cond_q.delete();
    for (int i = 0; i < 40; i++) begin
      pick = lcg_next() % 3;
      cond_q.push_back((pick == 0) ? i3c_pkg::EVT_START :
                       (pick == 1) ? i3c_pkg::EVT_STOP : i3c_pkg::EVT_HDR_EXIT);
    end
    ready_mode = READY_RAND;
    start_test(-1);
    play_conditions();
    end_test("random", 1'b0);

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, cmp_errors + seq_errors);
    if (n_failed == 0 && cmp_errors + seq_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: i3c_bus_watch.f
+incdir+sim
logic/i3c_pkg.sv
logic/line_filter.sv
logic/bus_monitor.sv
logic/event_fifo.sv
logic/bus_state_tracker.sv
logic/i3c_bus_watch.sv
sim/tb_i3c_bus_watch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the bus watcher testbench with Verilator

set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f i3c_bus_watch.f \
    --top-module tb_i3c_bus_watch 2>&1 | tee build.log \
  && ./obj_dir/Vtb_i3c_bus_watch 2>&1 | tee "$LOG" \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -q "FAIL: see errors above" "$LOG" \
  && { echo "Simulation reported failures"; exit 1; }

grep -q "PASS: all tests" "$LOG" \
  || { echo "No pass result in $LOG"; exit 1; }

echo "Simulation passed"
